/* disp_top.f */
+incdir+verilog
verilog/disp_pkg.sv
verilog/spi_pkg.sv
verilog/delay_line.sv
verilog/spi_slave.sv
verilog/cmd_decoder.sv
verilog/reset_controller.sv
verilog/framebuffer.sv
verilog/video_out.sv
verilog/disp_top.sv
tb/disp_top_sva.sv
tb/disp_top_tb.sv

/* Bender.yml */
package:
  name: disp_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/disp_pkg.sv
      - verilog/spi_pkg.sv
      - verilog/delay_line.sv
      - verilog/spi_slave.sv
      - verilog/cmd_decoder.sv
      - verilog/reset_controller.sv
      - verilog/framebuffer.sv
      - verilog/video_out.sv
      - verilog/disp_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/disp_top_sva.sv
      - tb/disp_top_tb.sv

/* tb/disp_top_tb.sv */
`include "disp_cfg.svh"

module disp_top_tb import disp_pkg::*; ();

    localparam int FRAME      = `H_TOTAL * `V_TOTAL;
    localparam int SPI_CYCLES = 40 * 4 * 8 * 8 + 40 * 32; // commands, bytes, bits, sck period
    localparam int TIMEOUT    = 20 * FRAME + SPI_CYCLES;

    logic clk_pix = 1'b0;
    logic rst;
    logic pll_locked;
    logic sck;
    logic cs_n;
    logic mosi;
    logic hsync;
    logic vsync;
    logic de;
    rgb_t rgb;
    logic busy;

    logic [3:0]  model [`FB_DEPTH]; // expected colour index per cell
    logic [11:0] frame [`FB_DEPTH];
    int          de_count;
    int          hs_count;
    int          vs_count;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors;
    int          cycle_count = 0;
    logic [31:0] rng = 32'd96;

    disp_top u_disp_top (.*);

    always #10 clk_pix = ~clk_pix;

    // watchdog
    always @(posedge clk_pix) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT) begin
            $display("timeout after %0d cycles, a wait never completed", TIMEOUT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic start_test();
        tests++;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
    endtask

    task automatic spi_send(input logic [7:0] b, input int nbits);
        for (int i = 0; i < nbits; i++) begin
            mosi = b[7-i]; // msb first
            sck  = 1'b0;
            repeat (4) @(negedge clk_pix);
            sck = 1'b1;
            repeat (4) @(negedge clk_pix);
        end
    endtask

    task automatic cs_low();
        cs_n = 1'b0;
        repeat (4) @(negedge clk_pix);
    endtask

    task automatic cs_high();
        sck = 1'b0;
        repeat (4) @(negedge clk_pix);
        cs_n = 1'b1;
        repeat (8) @(negedge clk_pix); // long enough for the write to land
    endtask

    task automatic send_cmd(input logic [7:0] op, input logic [7:0] x, input logic [7:0] y,
                            input logic [7:0] c);
        cs_low();
        spi_send(op, 8);
        spi_send(x, 8);
        spi_send(y, 8);
        spi_send(c, 8);
        cs_high();
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk_pix);
    endtask

    task automatic capture_frame();
        logic hs_prev;
        while (!vsync) @(negedge clk_pix);
        while (vsync) @(negedge clk_pix);
        de_count = 0;
        hs_count = 0;
        vs_count = 0;
        hs_prev  = hsync;
        repeat (FRAME) begin
            if (de) begin
                if (de_count < `FB_DEPTH) frame[de_count] = rgb;
                de_count++;
            end
            if (hsync && !hs_prev) hs_count++;
            if (vsync) vs_count++;
            hs_prev = hsync;
            @(negedge clk_pix);
        end
    endtask

    task automatic compare_frame();
        capture_frame();
        check("de_count", de_count, `FB_DEPTH);
        check("hsync pulses", hs_count, `V_TOTAL);
        check("vsync cycles", vs_count, (`VS_END - `VS_START) * `H_TOTAL); // one full line
        for (int i = 0; i < `FB_DEPTH; i++) begin
            check($sformatf("rgb[%0d]", i), frame[i], {model[i], model[i], model[i]});
        end
    endtask

    task automatic test_reset();
        start_test();
        check("busy", busy, 1'b1);
        wait_idle();
        compare_frame();
        end_test("reset and blank frame");
    endtask

    task automatic test_random_writes();
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] c;
        start_test();
        repeat (6) begin
            rng = xorshift(rng);
            x   = 8'(rng % `H_ACTIVE);
            rng = xorshift(rng);
            y   = 8'(rng % `V_ACTIVE);
            rng = xorshift(rng);
            c   = 8'(rng % 15 + 1); // nonzero so it shows up
            send_cmd(`OP_WRITE, x, y, c);
            model[y * `H_ACTIVE + x] = c[3:0];
        end
        compare_frame();
        end_test("random writes");
    endtask

    task automatic test_rejected();
        start_test();
        send_cmd(`OP_WRITE, 8'd16, 8'd2, 8'h7);
        send_cmd(`OP_WRITE, 8'd3, 8'd12, 8'h7);
        send_cmd(`OP_WRITE, 8'd200, 8'd200, 8'h7);
        send_cmd(8'h42, 8'd1, 8'd1, 8'h7); // unknown opcode
        compare_frame();
        end_test("rejected commands");
    endtask

    task automatic test_abort();
        start_test();
        cs_low();
        spi_send(`OP_WRITE, 8);
        spi_send(8'd3, 8);
        spi_send(8'd4, 8);
        spi_send(8'hA0, 3); // partial colour byte
        cs_high();
        send_cmd(`OP_WRITE, 8'd5, 8'd6, 8'h9);
        model[6 * `H_ACTIVE + 5] = 4'h9;
        compare_frame();
        end_test("cs_n abort");
    endtask

    task automatic test_wipe();
        start_test();
        cs_low();
        spi_send(`OP_WIPE, 8);
        cs_high();
        check("busy", busy, 1'b1);
        wait_idle();
        for (int i = 0; i < `FB_DEPTH; i++) model[i] = 4'h0;
        compare_frame();
        send_cmd(`OP_WRITE, 8'd15, 8'd11, 8'hC);
        model[11 * `H_ACTIVE + 15] = 4'hC;
        compare_frame();
        end_test("wipe all");
    endtask

    initial begin
        rst        = 1'b1;
        pll_locked = 1'b1;
        sck        = 1'b0;
        cs_n       = 1'b1;
        mosi       = 1'b0;
        for (int i = 0; i < `FB_DEPTH; i++) model[i] = 4'h0;
        repeat (10) @(negedge clk_pix);
        rst = 1'b0;
        test_reset();
        test_random_writes();
        test_rejected();
        test_abort();
        test_wipe();
        errors = errors + u_disp_top.u_disp_top_sva.fail_count; // assertion failures
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/disp_top_sva.sv */
module disp_top_sva import disp_pkg::*; (
    input logic   clk_pix,
    input logic   rst,
    input logic   soft_reset,
    input logic   rst_core,
    input logic   rst_protect,
    input fb_wr_t fb_wr,
    input logic   busy,
    input logic   hsync,
    input logic   vsync,
    input logic   de,
    input rgb_t   rgb
);

    int fail_count = 0; // assertion failures so far

    // pulse and protect rise together, protect drops one cycle later
    property soft_reset_seq;
        @(posedge clk_pix) disable iff (rst)
        soft_reset |=> ##1 (rst_protect && rst_core) ##1 (rst_protect && !rst_core)
            ##1 !rst_protect;
    endproperty

    a_soft_seq: assert property (soft_reset_seq)
        else begin
            $error("rst_protect does not outlast rst_core by one cycle");
            fail_count++;
        end

    a_de_sync: assert property (@(posedge clk_pix) disable iff (rst)
        de |-> !hsync && !vsync)
        else begin
            $error("de high during sync");
            fail_count++;
        end

    a_wr_busy: assert property (@(posedge clk_pix) disable iff (rst)
        fb_wr.en |-> !busy)
        else begin
            $error("framebuffer write while wipe busy");
            fail_count++;
        end

    a_rgb_blank: assert property (@(posedge clk_pix) disable iff (rst)
        !de |-> rgb == '0)
        else begin
            $error("rgb not zero outside de");
            fail_count++;
        end

endmodule

bind disp_top disp_top_sva u_disp_top_sva (
    .clk_pix     (clk_pix),
    .rst         (rst),
    .soft_reset  (soft_reset),
    .rst_core    (rst_core),
    .rst_protect (rst_protect),
    .fb_wr       (fb_wr),
    .busy        (busy),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .rgb         (rgb)
);

/* verilog/disp_top.sv */
module disp_top import disp_pkg::*, spi_pkg::*; (
    input  logic clk_pix,
    input  logic rst,
    input  logic pll_locked,
    input  logic sck,
    input  logic cs_n,
    input  logic mosi,
    output logic hsync,
    output logic vsync,
    output logic de,
    output rgb_t rgb,
    output logic busy
);

    spi_pins_t  pins;
    spi_byte_t  rx;
    fb_wr_t     fb_wr;
    logic       soft_reset;
    logic       rst_spi;
    logic       rst_core;
    logic       rst_protect;
    logic [7:0] fb_raddr;
    cidx_t      fb_rdata;

    assign pins = '{sck: sck, cs_n: cs_n, mosi: mosi};

    reset_controller u_reset_controller (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .pll_locked  (pll_locked),
        .soft_reset  (soft_reset),
        .rst_spi     (rst_spi),
        .rst_core    (rst_core),
        .rst_protect (rst_protect)
    );

    spi_slave u_spi_slave (
        .clk_pix (clk_pix),
        .rst     (rst_spi),
        .pins    (pins),
        .rx      (rx)
    );

    cmd_decoder u_cmd_decoder (
        .clk_pix     (clk_pix),
        .rst         (rst_spi),
        .rx          (rx),
        .rst_protect (rst_protect),
        .busy        (busy),
        .fb_wr       (fb_wr),
        .soft_reset  (soft_reset)
    );

    framebuffer u_framebuffer (
        .clk_pix (clk_pix),
        .rst     (rst_core),
        .wr      (fb_wr),
        .raddr   (fb_raddr),
        .rdata   (fb_rdata),
        .busy    (busy)
    );

    video_out u_video_out (
        .clk_pix  (clk_pix),
        .rst      (rst_core),
        .fb_raddr (fb_raddr),
        .fb_rdata (fb_rdata),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .rgb      (rgb)
    );

endmodule

/* verilog/video_out.sv */
`include "disp_cfg.svh"

module video_out import disp_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst,
    output logic [7:0] fb_raddr,
    input  cidx_t      fb_rdata,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output rgb_t       rgb
);

    coord_t  x;
    coord_t  y;
    timing_t tm_now;
    timing_t tm_out; // aligned with grey_q
    rgb_t    grey_q;

    always_ff @(posedge clk_pix or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else if (x == coord_t'(`H_TOTAL - 1)) begin
            x <= '0;
            y <= (y == coord_t'(`V_TOTAL - 1)) ? '0 : y + coord_t'(1);
        end else begin
            x <= x + coord_t'(1);
        end
    end

    always_comb begin
        tm_now.x     = x;
        tm_now.y     = y;
        tm_now.hsync = (x >= `HS_START) && (x < `HS_END);
        tm_now.vsync = (y >= `VS_START) && (y < `VS_END);
        tm_now.de    = (x < `H_ACTIVE) && (y < `V_ACTIVE);
    end

    // only active pixels hit the ram
    assign fb_raddr = tm_now.de ? 8'(y * `H_ACTIVE + x) : '0;

    // ram read plus palette stage
    delay_line #(
        .T     (timing_t),
        .DEPTH (2)
    ) u_tm_delay (
        .clk_pix (clk_pix),
        .rst     (rst),
        .d       (tm_now),
        .q       (tm_out)
    );

    always_ff @(posedge clk_pix) begin
        grey_q <= '{r: fb_rdata, g: fb_rdata, b: fb_rdata}; // grey ramp
    end

    assign hsync = tm_out.hsync;
    assign vsync = tm_out.vsync;
    assign de    = tm_out.de;
    assign rgb   = tm_out.de ? grey_q : '0;

endmodule

/* verilog/framebuffer.sv */
`include "disp_cfg.svh"

module framebuffer import disp_pkg::*; (
    input  logic       clk_pix,
    input  logic       rst,
    input  fb_wr_t     wr,
    input  logic [7:0] raddr,
    output cidx_t      rdata,
    output logic       busy
);

    cidx_t      mem [`FB_DEPTH];
    logic [7:0] wipe_addr;

    // wipe runs once after every core reset
    always_ff @(posedge clk_pix or posedge rst) begin
        if (rst) begin
            busy      <= 1'b1;
            wipe_addr <= '0;
        end else if (busy) begin
            wipe_addr <= wipe_addr + 8'd1;
            if (wipe_addr == 8'(`FB_DEPTH - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (busy) begin
            mem[wipe_addr] <= '0; // wipe owns the write port
        end else if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
        rdata <= mem[raddr];
    end

endmodule

/* verilog/reset_controller.sv */
module reset_controller (
    input  logic clk_pix,
    input  logic rst,
    input  logic pll_locked,
    input  logic soft_reset,
    output logic rst_spi,
    output logic rst_core,
    output logic rst_protect
);

    logic [1:0] rst_sync;
    logic [1:0] lock_sync;
    logic [1:0] soft_ctr;
    logic       soft_pulse;

    // async assert, release after two clean edges
    always_ff @(posedge clk_pix or posedge rst) begin
        if (rst) begin
            rst_sync <= 2'b11;
        end else begin
            rst_sync <= {rst_sync[0], 1'b0};
        end
    end

    assign rst_spi = rst_sync[1];

    always_ff @(posedge clk_pix or posedge rst_spi) begin
        if (rst_spi) begin
            lock_sync <= '0;
        end else begin
            lock_sync <= {lock_sync[0], pll_locked};
        end
    end

    // soft reset sequence, protect is held one cycle past the pulse
    always_ff @(posedge clk_pix or posedge rst_spi) begin
        if (rst_spi) begin
            soft_ctr    <= '0;
            soft_pulse  <= 1'b0;
            rst_protect <= 1'b0;
        end else begin
            if (soft_ctr == 2'd3) begin
                rst_protect <= 1'b0;
                soft_ctr    <= '0;
            end else if (soft_ctr == 2'd2) begin
                soft_pulse <= 1'b0; // core comes out of reset
                soft_ctr   <= 2'd3;
            end else if (soft_ctr == 2'd1) begin
                soft_pulse  <= 1'b1;
                rst_protect <= 1'b1;
                soft_ctr    <= 2'd2;
            end else if (soft_reset) begin
                soft_ctr <= 2'd1;
            end
        end
    end

    assign rst_core = rst_spi || !lock_sync[1] || soft_pulse;

endmodule

/* verilog/cmd_decoder.sv */
`include "disp_cfg.svh"

module cmd_decoder import disp_pkg::*, spi_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst,
    input  spi_byte_t rx,
    input  logic      rst_protect,
    input  logic      busy,
    output fb_wr_t    fb_wr,
    output logic      soft_reset
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_X,
        ST_Y,
        ST_C
    } state_e;

    state_e     state;
    logic [7:0] x_q; // full byte kept so large values fail the range check
    logic [7:0] y_q;
    logic       in_range;

    assign in_range = (x_q < `H_ACTIVE) && (y_q < `V_ACTIVE);

    always_ff @(posedge clk_pix or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            x_q        <= '0;
            y_q        <= '0;
            fb_wr      <= '0;
            soft_reset <= 1'b0;
        end else begin
            fb_wr.en   <= 1'b0;
            soft_reset <= 1'b0;
            if (rx.valid && !rst_protect) begin
                if (rx.first) begin
                    // new transfer, any command in progress is abandoned
                    case (opcode_e'(rx.data))
                        OP_WRITE_PIXEL: state <= ST_X;
                        OP_WIPE_ALL: begin
                            soft_reset <= 1'b1;
                            state      <= ST_IDLE;
                        end
                        default: state <= ST_IDLE; // unknown opcode
                    endcase
                end else begin
                    case (state)
                        ST_X: begin
                            x_q   <= rx.data;
                            state <= ST_Y;
                        end
                        ST_Y: begin
                            y_q   <= rx.data;
                            state <= ST_C;
                        end
                        ST_C: begin
                            state <= ST_IDLE;
                            if (in_range && !busy) begin
                                fb_wr.en   <= 1'b1;
                                fb_wr.addr <= 8'(y_q * `H_ACTIVE + x_q);
                                fb_wr.data <= rx.data[3:0];
                            end
                        end
                        default: state <= ST_IDLE; // stray bytes
                    endcase
                end
            end
        end
    end

endmodule

/* verilog/spi_slave.sv */
`include "disp_cfg.svh"

module spi_slave import spi_pkg::*; (
    input  logic      clk_pix,
    input  logic      rst,
    input  spi_pins_t pins,
    output spi_byte_t rx
);

    spi_pins_t  pins_s;   // synchronised pins
    logic       sck_prev; // one cycle older, for edge detect
    logic       sck_rise;
    logic [2:0] bit_cnt;
    logic [6:0] shift;
    logic       first_pend;

    // async pins into clk_pix domain
    delay_line #(
        .T     (spi_pins_t),
        .DEPTH (`SYNC_STAGES)
    ) u_pin_sync (
        .clk_pix (clk_pix),
        .rst     (rst),
        .d       (pins),
        .q       (pins_s)
    );

    assign sck_rise = pins_s.sck && !sck_prev;

    always_ff @(posedge clk_pix or posedge rst) begin
        if (rst) begin
            sck_prev   <= 1'b0;
            bit_cnt    <= '0;
            shift      <= '0;
            first_pend <= 1'b1;
            rx         <= '0;
        end else begin
            sck_prev <= pins_s.sck;
            rx.valid <= 1'b0; // strobe
            if (pins_s.cs_n) begin
                // deselected, drop any partial byte
                bit_cnt    <= '0;
                first_pend <= 1'b1;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                shift   <= {shift[5:0], pins_s.mosi}; // msb first
                if (bit_cnt == 3'd7) begin
                    rx.valid   <= 1'b1;
                    rx.data    <= {shift, pins_s.mosi};
                    rx.first   <= first_pend;
                    first_pend <= 1'b0;
                end
            end
        end
    end

endmodule

/* verilog/delay_line.sv */
module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk_pix,
    input  logic rst,
    input  T     d,
    output T     q
);

    T stage [DEPTH];

    always_ff @(posedge clk_pix or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

/* verilog/spi_pkg.sv */
`include "disp_cfg.svh"

package spi_pkg;

    typedef struct packed {
        logic sck;
        logic cs_n;
        logic mosi;
    } spi_pins_t;

    // received byte, valid is a one cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       first; // first byte after cs_n went low
    } spi_byte_t;

    typedef enum logic [7:0] {
        OP_WRITE_PIXEL = `OP_WRITE,
        OP_WIPE_ALL    = `OP_WIPE
    } opcode_e;

endpackage

/* verilog/disp_pkg.sv */
package disp_pkg;

    typedef logic [4:0] coord_t; // raster x or y
    typedef logic [3:0] cidx_t;  // colour index

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // one raster position with its sync state
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   hsync;
        logic   vsync;
        logic   de;
    } timing_t;

    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        cidx_t      data;
    } fb_wr_t;

endpackage

/* verilog/disp_cfg.svh */
`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// visible area, in framebuffer cells
`define H_ACTIVE 16
`define V_ACTIVE 12

// full raster including blanking
`define H_TOTAL 24
`define V_TOTAL 16

`define HS_START 18 // hsync columns [HS_START, HS_END)
`define HS_END 21
`define VS_START 13 // vsync rows [VS_START, VS_END)
`define VS_END 14

`define FB_DEPTH (`H_ACTIVE * `V_ACTIVE)

`define OP_WRITE 8'h01
`define OP_WIPE 8'hFF

`define SYNC_STAGES 2

`endif
